/* alu_block/alu_block.sv */
module alu_block (
    input  exec_pkg::exec_operands_t operands,
    input  exec_pkg::exec_cmd_t      cmd,
    input  exec_pkg::nzcv_t          flags_in,
    output exec_pkg::exec_result_t   result
);
    import exec_pkg::*;

    word_t shifted;
    logic  shifter_carry;
    word_t b_op;
    word_t src_a;
    word_t pre_b;
    word_t src_b;
    word_t alu_result;
    logic  alu_carry;
    logic  alu_overflow;
    word_t mul_lo;
    word_t mul_hi;
    logic  mul_long;
    logic  arith;
    word_t sel_out;
    word_t res1;

    barrel_shifter shifter_i (
        .value     (operands.b),
        .shift_reg (operands.s),
        .kind      (cmd.shift_kind),
        .amount    (cmd.shift_amount),
        .by_reg    (cmd.shift_by_reg),
        .no_shift  (cmd.no_shift),
        .carry_in  (flags_in.c),
        .shifted   (shifted),
        .carry_out (shifter_carry)
    );

    // ******************************
    // Operand preparation
    // ******************************
    assign b_op  = cmd.use_imm ? operands.imm : shifted;
    assign src_a = cmd.swap ? b_op : operands.a;
    assign pre_b = cmd.swap ? operands.a : b_op;
    assign src_b = cmd.invert ? ~pre_b : pre_b;

    alu_core alu_i (
        .a         (src_a),
        .b         (src_b),
        .op        (cmd.alu_op),
        .carry_in  (flags_in.c),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    // Product of b and s, accumulated with d as high word and a as low word
    multiplier mul_i (
        .a      (operands.b),
        .b      (operands.s),
        .acc_lo (operands.a),
        .acc_hi (operands.d),
        .op     (cmd.mul_op),
        .lo     (mul_lo),
        .hi     (mul_hi)
    );

    // ******************************
    // Result and flag selection
    // ******************************
    assign mul_long = cmd.mul_op != MUL_MUL && cmd.mul_op != MUL_MLA;
    assign arith    = cmd.alu_op == ALU_ADD || cmd.alu_op == ALU_ADD1 || cmd.alu_op == ALU_ADC;

    always_comb begin
        unique case (cmd.res_sel)
            SEL_B:   sel_out = src_b;
            SEL_A:   sel_out = operands.a;
            default: sel_out = alu_result;
        endcase
    end

    assign res1        = cmd.mul_en ? (mul_long ? mul_hi : mul_lo) : sel_out;
    assign result.res1 = res1;
    assign result.res2 = cmd.mul_en ? mul_lo : alu_result;

    always_comb begin
        result.flags = flags_in;
        if (cmd.set_flags) begin
            result.flags.n = res1[31];
            result.flags.z = res1 == 32'd0;
            if (!cmd.mul_en) begin
                if (cmd.res_sel == SEL_ALU && arith) begin
                    result.flags.c = alu_carry;
                    result.flags.v = alu_overflow;
                end else begin
                    result.flags.c = shifter_carry;
                end
            end
        end
    end

endmodule

/* alu_block/alu_core.sv */
module alu_core (
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::alu_op_t op,
    input  logic              carry_in,
    output exec_pkg::word_t   result,
    output logic              carry_out,
    output logic              overflow
);
    import exec_pkg::*;

    logic        cin;
    logic [32:0] sum;

    always_comb begin
        unique case (op)
            ALU_ADD1: cin = 1'b1;
            ALU_ADC:  cin = carry_in;
            default:  cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, a} + {1'b0, b} + {32'd0, cin};

    always_comb begin
        carry_out = 1'b0;
        overflow  = 1'b0;
        unique case (op)
            ALU_AND: result = a & b;
            ALU_ORR: result = a | b;
            ALU_EOR: result = a ^ b;
            default: begin
                result    = sum[31:0];
                carry_out = sum[32];
                // Signed overflow when like signs give a result of the other sign
                overflow  = (a[31] == b[31]) && (sum[31] != a[31]);
            end
        endcase
    end

endmodule

/* alu_block/barrel_shifter.sv */
module barrel_shifter (
    input  exec_pkg::word_t  value,
    input  exec_pkg::word_t  shift_reg,
    input  exec_pkg::shift_t kind,
    input  logic [4:0]       amount,
    input  logic             by_reg,
    input  logic             no_shift,
    input  logic             carry_in,
    output exec_pkg::word_t  shifted,
    output logic             carry_out
);
    import exec_pkg::*;

    logic [8:0]  count;
    logic        rrx;
    logic [32:0] lsl_ext;
    logic [32:0] lsr_ext;
    logic [32:0] asr_ext;
    logic [4:0]  rot;
    word_t       rotated;

    // Only the low byte of the shift register counts
    always_comb begin
        if (by_reg) begin
            count = {1'b0, shift_reg[7:0]};
        end else if (amount == 5'd0 && (kind == SH_LSR || kind == SH_ASR)) begin
            count = 9'd32;
        end else begin
            count = {4'd0, amount};
        end
    end

    assign rrx = !by_reg && kind == SH_ROR && amount == 5'd0;

    // The spare bit of each extended word catches the last bit shifted out
    assign lsl_ext = {1'b0, value} << count;
    assign lsr_ext = {value, 1'b0} >> count;
    assign asr_ext = $signed({value, 1'b0}) >>> count;
    assign rot     = count[4:0];
    assign rotated = (value >> rot) | (value << (6'd32 - {1'b0, rot}));

    always_comb begin
        if (no_shift || (count == 9'd0 && !rrx)) begin
            shifted   = value;
            carry_out = carry_in;
        end else if (rrx) begin
            shifted   = {carry_in, value[31:1]};
            carry_out = value[0];
        end else begin
            unique case (kind)
                SH_LSL: begin
                    shifted   = lsl_ext[31:0];
                    carry_out = lsl_ext[32];
                end
                SH_LSR: begin
                    shifted   = lsr_ext[32:1];
                    carry_out = lsr_ext[0];
                end
                SH_ASR: begin
                    shifted   = asr_ext[32:1];
                    carry_out = asr_ext[0];
                end
                default: begin
                    // Bit 31 of a rotation is always the last bit out, also for multiples of 32
                    shifted   = rotated;
                    carry_out = rotated[31];
                end
            endcase
        end
    end

endmodule

/* alu_block/multiplier.sv */
module multiplier (
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::word_t   acc_lo,
    input  exec_pkg::word_t   acc_hi,
    input  exec_pkg::mul_op_t op,
    output exec_pkg::word_t   lo,
    output exec_pkg::word_t   hi
);
    import exec_pkg::*;

    logic        is_signed;
    logic        is_long;
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] product;
    logic [63:0] acc;
    logic [63:0] total;

    assign is_signed = op == MUL_SMULL || op == MUL_SMLAL;
    assign is_long   = op == MUL_UMULL || op == MUL_SMULL || op == MUL_UMLAL || op == MUL_SMLAL;

    // With both factors extended to 64 bits the low half of the product is exact
    assign a_ext   = {{32{is_signed & a[31]}}, a};
    assign b_ext   = {{32{is_signed & b[31]}}, b};
    assign product = a_ext * b_ext;

    always_comb begin
        unique case (op)
            MUL_MLA:   acc = {32'd0, acc_lo};
            MUL_UMLAL: acc = {acc_hi, acc_lo};
            MUL_SMLAL: acc = {acc_hi, acc_lo};
            default:   acc = 64'd0;
        endcase
    end

    assign total = product + acc;
    assign lo    = total[31:0];
    assign hi    = is_long ? total[63:32] : 32'd0;

endmodule

/* common/exec_pkg.sv */
package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  apb_addr_t;

    typedef enum logic [1:0] {
        SH_LSL = 2'd0,
        SH_LSR = 2'd1,
        SH_ASR = 2'd2,
        SH_ROR = 2'd3
    } shift_t;

    // ADD1 adds one more, so a plus inverted b is a subtraction
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_ADD1 = 3'd1,
        ALU_ADC  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_ORR  = 3'd4,
        ALU_EOR  = 3'd5
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_ALU = 2'd0,
        SEL_B   = 2'd1,
        SEL_A   = 2'd2
    } res_sel_t;

    typedef enum logic [2:0] {
        MUL_MUL   = 3'd0,
        MUL_MLA   = 3'd1,
        MUL_UMULL = 3'd2,
        MUL_SMULL = 3'd3,
        MUL_UMLAL = 3'd4,
        MUL_SMLAL = 3'd5
    } mul_op_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    // ******************************
    // CMD register layout, first field in the top bits
    // ******************************
    typedef struct packed {
        shift_t     shift_kind;
        logic [4:0] shift_amount;
        logic       shift_by_reg;
        logic       no_shift;
        logic       use_imm;
        logic       swap;
        logic       invert;
        alu_op_t    alu_op;
        res_sel_t   res_sel;
        logic       mul_en;
        mul_op_t    mul_op;
        logic       set_flags;
    } exec_cmd_t;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t s;
        word_t d;
        word_t imm;
    } exec_operands_t;

    typedef struct packed {
        word_t res1;
        word_t res2;
        nzcv_t flags;
    } exec_result_t;

    localparam apb_addr_t REG_OP_A  = 8'h00;
    localparam apb_addr_t REG_OP_B  = 8'h04;
    localparam apb_addr_t REG_OP_S  = 8'h08;
    localparam apb_addr_t REG_OP_D  = 8'h0C;
    localparam apb_addr_t REG_IMM   = 8'h10;
    localparam apb_addr_t REG_CMD   = 8'h14;
    localparam apb_addr_t REG_RES1  = 8'h18;
    localparam apb_addr_t REG_RES2  = 8'h1C;
    localparam apb_addr_t REG_FLAGS = 8'h20;

endpackage

/* compile.f */
common/exec_pkg.sv
alu_block/barrel_shifter.sv
alu_block/alu_core.sv
alu_block/multiplier.sv
alu_block/alu_block.sv
hdl/apb_exec_regs.sv
hdl/exec_top.sv
tb/exec_top_chk.sv
tb/exec_top_tb.sv

/* hdl/apb_exec_regs.sv */
module apb_exec_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  exec_pkg::apb_addr_t      paddr,
    input  exec_pkg::word_t          pwdata,
    input  exec_pkg::exec_result_t   result,
    output exec_pkg::word_t          prdata,
    output logic                     pready,
    output logic                     pslverr,
    output exec_pkg::exec_operands_t operands,
    output exec_pkg::exec_cmd_t      cmd,
    output exec_pkg::nzcv_t          flags
);
    import exec_pkg::*;

    logic  access;
    logic  mapped;
    logic  read_only;
    logic  wr_en;
    logic  start;
    word_t res1_q;
    word_t res2_q;

    assign access = psel && penable;

    always_comb begin
        unique case (paddr)
            REG_OP_A, REG_OP_B, REG_OP_S, REG_OP_D, REG_IMM, REG_CMD, REG_FLAGS: begin
                mapped    = 1'b1;
                read_only = 1'b0;
            end
            REG_RES1, REG_RES2: begin
                mapped    = 1'b1;
                read_only = 1'b1;
            end
            default: begin
                mapped    = 1'b0;
                read_only = 1'b0;
            end
        endcase
    end

    // No wait states, so every transfer ends in its access cycle
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && read_only));
    assign wr_en   = access && pwrite && !pslverr;

    always_ff @(posedge clk) begin
        if (reset) begin
            operands <= '0;
            cmd      <= '0;
            flags    <= '0;
            res1_q   <= '0;
            res2_q   <= '0;
            start    <= 1'b0;
        end else begin
            start <= wr_en && paddr == REG_CMD;
            if (wr_en) begin
                unique case (paddr)
                    REG_OP_A:  operands.a   <= pwdata;
                    REG_OP_B:  operands.b   <= pwdata;
                    REG_OP_S:  operands.s   <= pwdata;
                    REG_OP_D:  operands.d   <= pwdata;
                    REG_IMM:   operands.imm <= pwdata;
                    REG_CMD:   cmd          <= exec_cmd_t'(pwdata[$bits(exec_cmd_t)-1:0]);
                    REG_FLAGS: flags        <= nzcv_t'(pwdata[3:0]);
                    default:   ;
                endcase
            end
            // Capture happens in the setup cycle after the CMD write, never during a write
            if (start) begin
                res1_q <= result.res1;
                res2_q <= result.res2;
                if (cmd.set_flags) begin
                    flags <= result.flags;
                end
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            unique case (paddr)
                REG_OP_A:  prdata = operands.a;
                REG_OP_B:  prdata = operands.b;
                REG_OP_S:  prdata = operands.s;
                REG_OP_D:  prdata = operands.d;
                REG_IMM:   prdata = operands.imm;
                REG_CMD:   prdata = {{(32 - $bits(exec_cmd_t)){1'b0}}, cmd};
                REG_RES1:  prdata = res1_q;
                REG_RES2:  prdata = res2_q;
                REG_FLAGS: prdata = {28'd0, flags};
                default:   prdata = '0;
            endcase
        end
    end

endmodule

/* hdl/exec_top.sv */
module exec_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  exec_pkg::apb_addr_t paddr,
    input  exec_pkg::word_t     pwdata,
    output exec_pkg::word_t     prdata,
    output logic                pready,
    output logic                pslverr
);
    import exec_pkg::*;

    exec_operands_t operands;
    exec_cmd_t      cmd;
    nzcv_t          flags;
    exec_result_t   result;

    apb_exec_regs regs_i (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .result   (result),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .operands (operands),
        .cmd      (cmd),
        .flags    (flags)
    );

    // Datapath works on the stored registers and is captured one cycle after the CMD write
    alu_block alu_block_i (
        .operands (operands),
        .cmd      (cmd),
        .flags_in (flags),
        .result   (result)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module exec_top_tb -o exec_top_sim

# A raised error limit lets the testbench report the first checker error itself
./obj_dir/exec_top_sim +verilator+error+limit+100 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* tb/exec_top_chk.sv */
module exec_top_chk (
    input logic                clk,
    input logic                reset,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input exec_pkg::apb_addr_t paddr,
    input exec_pkg::word_t     pwdata,
    input exec_pkg::word_t     prdata,
    input logic                pready,
    input logic                pslverr
);
    import exec_pkg::*;

    int           error_count = 0;
    word_t        shadow [0:8];
    logic         access;
    logic         known;
    logic         exp_err;
    word_t        exp_rdata;
    exec_result_t next_res;

    // Shifts one bit per step, so the carry is simply the last bit that fell off
    function automatic logic [32:0] shift_model(word_t v, word_t s, exec_cmd_t cm, logic cin);
        int   n;
        logic cy;
        n  = cm.shift_by_reg ? int'(s[7:0]) : int'(cm.shift_amount);
        cy = cin;
        if (cm.no_shift) begin
            n = 0;
        end else if (!cm.shift_by_reg && n == 0 && cm.shift_kind == SH_ROR) begin
            return {v[0], cin, v[31:1]};
        end else if (!cm.shift_by_reg && n == 0 && cm.shift_kind != SH_LSL) begin
            n = 32;
        end
        for (int i = 0; i < n; i++) begin
            case (cm.shift_kind)
                SH_LSL: begin
                    cy = v[31];
                    v  = {v[30:0], 1'b0};
                end
                SH_LSR: begin
                    cy = v[0];
                    v  = {1'b0, v[31:1]};
                end
                SH_ASR: begin
                    cy = v[0];
                    v  = {v[31], v[31:1]};
                end
                default: begin
                    cy = v[0];
                    v  = {v[0], v[31:1]};
                end
            endcase
        end
        return {cy, v};
    endfunction

    function automatic exec_result_t model_op(word_t a, word_t b, word_t s, word_t d,
                                              word_t imm, exec_cmd_t cm, nzcv_t f);
        exec_result_t r;
        logic [32:0]  sh;
        word_t        x;
        word_t        y;
        word_t        alu;
        logic         cin;
        logic         arith;
        logic [32:0]  sum;
        longint       ssum;
        logic [63:0]  prod;
        sh = shift_model(b, s, cm, f.c);
        x  = cm.use_imm ? imm : sh[31:0];
        y  = a;
        if (!cm.swap) begin
            y = x;
            x = a;
        end
        if (cm.invert) begin
            y = ~y;
        end
        cin   = (cm.alu_op == ALU_ADD1) || (cm.alu_op == ALU_ADC && f.c);
        arith = cm.alu_op inside {ALU_ADD, ALU_ADD1, ALU_ADC};
        sum   = {1'b0, x} + {1'b0, y} + {32'd0, cin};
        ssum  = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
        case (cm.alu_op)
            ALU_AND: alu = x & y;
            ALU_ORR: alu = x | y;
            ALU_EOR: alu = x ^ y;
            default: alu = sum[31:0];
        endcase
        r.flags = f;
        if (cm.mul_en) begin
            if (cm.mul_op == MUL_SMULL || cm.mul_op == MUL_SMLAL) begin
                prod = longint'($signed(b)) * longint'($signed(s));
            end else begin
                prod = {32'd0, b} * {32'd0, s};
            end
            case (cm.mul_op)
                MUL_MLA:              prod = prod + {32'd0, a};
                MUL_UMLAL, MUL_SMLAL: prod = prod + {d, a};
                default:              prod = prod;
            endcase
            r.res2 = prod[31:0];
            r.res1 = (cm.mul_op inside {MUL_MUL, MUL_MLA}) ? prod[31:0] : prod[63:32];
        end else begin
            r.res2 = alu;
            case (cm.res_sel)
                SEL_B:   r.res1 = y;
                SEL_A:   r.res1 = a;
                default: r.res1 = alu;
            endcase
        end
        if (cm.set_flags) begin
            r.flags.n = r.res1[31];
            r.flags.z = r.res1 == 32'd0;
            if (!cm.mul_en && cm.res_sel == SEL_ALU && arith) begin
                r.flags.c = sum[32];
                r.flags.v = ssum != longint'($signed(sum[31:0]));
            end else if (!cm.mul_en) begin
                r.flags.c = sh[32];
            end
        end
        return r;
    endfunction

    assign access    = psel && penable;
    assign known     = paddr[1:0] == 2'b00 && paddr <= REG_FLAGS;
    assign exp_err   = access && (!known || (pwrite && (paddr == REG_RES1 || paddr == REG_RES2)));
    assign exp_rdata = (access && !pwrite && known) ? shadow[paddr[5:2]] : 32'd0;
    assign next_res  = model_op(shadow[0], shadow[1], shadow[2], shadow[3], shadow[4],
                                exec_cmd_t'(pwdata[$bits(exec_cmd_t)-1:0]),
                                nzcv_t'(shadow[8][3:0]));

    // ******************************
    // Shadow copy of the register map
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 9; i++) begin
                shadow[i] <= 32'd0;
            end
        end else if (access && pwrite && !exp_err) begin
            case (paddr)
                REG_CMD: begin
                    shadow[5] <= pwdata & ((32'd1 << $bits(exec_cmd_t)) - 32'd1);
                    shadow[6] <= next_res.res1;
                    shadow[7] <= next_res.res2;
                    shadow[8] <= {28'd0, next_res.flags};
                end
                REG_FLAGS: shadow[8] <= {28'd0, pwdata[3:0]};
                default:   shadow[paddr[5:2]] <= pwdata;
            endcase
        end
    end

    read_data_ok: assert property (@(posedge clk) disable iff (reset) prdata == exp_rdata)
        else begin
            error_count = error_count + 1;
            $error("prdata %h at address %h, expected %h", prdata, paddr, exp_rdata);
        end

    slverr_ok: assert property (@(posedge clk) disable iff (reset)
                                pslverr == exp_err && pready)
        else begin
            error_count = error_count + 1;
            $error("pslverr %b at address %h, expected %b", pslverr, paddr, exp_err);
        end

endmodule

bind exec_top exec_top_chk chk_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
);

/* tb/exec_top_tb.sv */
module exec_top_tb;
    import exec_pkg::*;

    logic      clk;
    logic      reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;
    int        seed;
    exec_cmd_t cmd;

    int    imm_amounts [4] = '{0, 1, 7, 31};
    int    reg_counts [6]  = '{0, 1, 31, 32, 33, 200};
    word_t corner_a [5]    = '{32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000, 32'd0, 32'h8000_0000};
    word_t corner_b [5]    = '{32'h0000_0001, 32'h0000_0001, 32'h8000_0000, 32'd0, 32'h0000_0001};

    exec_top exec_top_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;

    // The bound checker counts failed assertions
    always @(negedge clk) begin
        if (exec_top_i.chk_i.error_count != 0) begin
            $display("FAILED at time %0t: checker found a wrong APB response", $time);
            $display("Something failed");
            $fatal(1, "Stopped at the first checker error");
        end
    end

    // Called at a falling edge, returns at the falling edge after the access cycle
    task automatic apb_transfer(input logic is_write, input apb_addr_t addr, input word_t data);
        int wait_cycles;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable     = 1'b1;
        wait_cycles = 0;
        while (pready !== 1'b1 && wait_cycles < 16) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pready !== 1'b1) begin
            $display("APB transfer to address %h never saw pready", addr);
            $display("Something failed");
            $fatal(1, "APB transfer timed out");
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input word_t data);
        apb_transfer(1'b1, addr, data);
    endtask

    task automatic read_reg(input apb_addr_t addr);
        apb_transfer(1'b0, addr, 32'd0);
    endtask

    task automatic load_operands(input word_t a, input word_t b, input word_t s, input word_t d,
                                 input word_t imm);
        write_reg(REG_OP_A, a);
        write_reg(REG_OP_B, b);
        write_reg(REG_OP_S, s);
        write_reg(REG_OP_D, d);
        write_reg(REG_IMM, imm);
    endtask

    task automatic run_cmd(input exec_cmd_t c);
        write_reg(REG_CMD, 32'(c));
        read_reg(REG_RES1);
        read_reg(REG_RES2);
        read_reg(REG_FLAGS);
        read_reg(REG_CMD);
    endtask

    initial begin
        word_t rnd;
        seed    = 32'hbbf7;
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'd0;
        pwdata  = 32'd0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // ******************************
        // Reset values and readback
        // ******************************
        for (int i = 0; i <= 8; i++) begin
            read_reg(apb_addr_t'(i * 4));
        end
        load_operands($random(seed), $random(seed), $random(seed), $random(seed), $random(seed));
        write_reg(REG_FLAGS, $random(seed));
        for (int i = 0; i <= 8; i++) begin
            read_reg(apb_addr_t'(i * 4));
        end

        // Shifter as a move, by immediate and by register
        cmd           = '0;
        cmd.res_sel   = SEL_B;
        cmd.set_flags = 1'b1;
        for (int k = 0; k < 4; k++) begin
            cmd.shift_kind   = shift_t'(k);
            cmd.shift_by_reg = 1'b0;
            for (int j = 0; j < 4; j++) begin
                cmd.shift_amount = 5'(imm_amounts[j]);
                load_operands($random(seed), $random(seed), $random(seed), 32'd0, 32'd0);
                write_reg(REG_FLAGS, $random(seed));
                run_cmd(cmd);
            end
            cmd.shift_by_reg = 1'b1;
            for (int j = 0; j < 6; j++) begin
                rnd = $random(seed);
                load_operands($random(seed), $random(seed), {rnd[31:8], 8'(reg_counts[j])},
                              32'd0, 32'd0);
                write_reg(REG_FLAGS, $random(seed));
                run_cmd(cmd);
            end
        end
        cmd.no_shift = 1'b1;
        run_cmd(cmd);

        // ******************************
        // ALU operations
        // ******************************
        cmd           = '0;
        cmd.res_sel   = SEL_ALU;
        cmd.set_flags = 1'b1;
        for (int op = 0; op < 6; op++) begin
            cmd.alu_op = alu_op_t'(op);
            cmd.invert = alu_op_t'(op) == ALU_ADD1;
            for (int m = 0; m < 4; m++) begin
                cmd.swap         = m[0];
                cmd.use_imm      = m[1];
                cmd.shift_kind   = shift_t'(m);
                cmd.shift_amount = 5'(3 * m + 1);
                load_operands($random(seed), $random(seed), $random(seed), $random(seed),
                              $random(seed));
                write_reg(REG_FLAGS, $random(seed));
                run_cmd(cmd);
            end
        end
        cmd.swap     = 1'b0;
        cmd.use_imm  = 1'b0;
        cmd.no_shift = 1'b1;
        for (int op = 0; op < 3; op++) begin
            cmd.alu_op = alu_op_t'(op);
            cmd.invert = alu_op_t'(op) == ALU_ADD1;
            for (int j = 0; j < 5; j++) begin
                load_operands(corner_a[j], corner_b[j], 32'd0, 32'd0, 32'd0);
                write_reg(REG_FLAGS, $random(seed));
                run_cmd(cmd);
            end
        end
        cmd.res_sel = SEL_A;
        run_cmd(cmd);

        // Multiply forms with negative factors in the first rounds
        cmd           = '0;
        cmd.mul_en    = 1'b1;
        cmd.set_flags = 1'b1;
        for (int op = 0; op < 6; op++) begin
            cmd.mul_op = mul_op_t'(op);
            for (int j = 0; j < 3; j++) begin
                rnd = $random(seed);
                load_operands($random(seed), rnd | (j == 0 ? 32'h8000_0000 : 32'd0),
                              $random(seed) | (j < 2 ? 32'h8000_0000 : 32'd0),
                              $random(seed), 32'd0);
                write_reg(REG_FLAGS, $random(seed));
                run_cmd(cmd);
            end
        end

        // Flags stay as written when set_flags is clear
        write_reg(REG_FLAGS, 32'h0000_000A);
        cmd        = '0;
        cmd.alu_op = ALU_ADD;
        run_cmd(cmd);

        // ******************************
        // Slave errors
        // ******************************
        write_reg(REG_RES1, $random(seed));
        write_reg(REG_RES2, $random(seed));
        write_reg(8'h24, $random(seed));
        read_reg(8'h24);
        write_reg(8'h06, $random(seed));
        read_reg(8'hFC);
        for (int i = 0; i <= 8; i++) begin
            read_reg(apb_addr_t'(i * 4));
        end

        @(negedge clk);
        if (exec_top_i.chk_i.error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
